// ==== Bender.yml ====
package:
  name: cdc_stream

sources:
  - common/cdc_stream_pkg.sv
  - hw/gray_counter.sv
  - async_fifo/dual_port_ram.sv
  - async_fifo/async_fifo.sv
  - hw/sample_framer.sv
  - hw/sample_receiver.sv
  - hw/cdc_stream_top.sv
  - target: test
    files:
      - test/cdc_stream_props.sv
      - test/cdc_stream_tb.sv

// ==== async_fifo/async_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

// gray pointer async fifo, write side on clk and read side on rd_clk
module async_fifo #(
  parameter type payload_t = logic [cdc_stream_pkg::data_width-1:0]
) (
  // write domain
  input  logic     clk,
  input  logic     reset,
  input  logic     wr_en,
  input  payload_t wr_data,
  output logic     full,

  // read domain
  input  logic     rd_clk,
  input  logic     rd_en,
  output payload_t rd_data,
  output logic     empty,
  output logic     rd_reset
);

  logic [cdc_stream_pkg::ptr_width-1:0] wr_bin;
  logic [cdc_stream_pkg::ptr_width-1:0] wr_gray;
  logic [cdc_stream_pkg::ptr_width-1:0] rd_bin;
  logic [cdc_stream_pkg::ptr_width-1:0] rd_gray;

  // read pointer seen from the write side
  logic [cdc_stream_pkg::ptr_width-1:0] rd_gray_sync1;
  logic [cdc_stream_pkg::ptr_width-1:0] rd_gray_sync2;
  logic [cdc_stream_pkg::ptr_width-1:0] rd_bin_wr;
  logic [cdc_stream_pkg::ptr_width-1:0] fill_level;

  // write pointer seen from the read side
  logic [cdc_stream_pkg::ptr_width-1:0] wr_gray_sync1;
  logic [cdc_stream_pkg::ptr_width-1:0] wr_gray_sync2;

  logic rd_reset_meta;

  // reset crossing into rd_clk
  always_ff @(posedge rd_clk) begin
    rd_reset_meta <= reset;
    rd_reset      <= rd_reset_meta;
  end

  dual_port_ram #(
    .payload_t(payload_t)
  ) ram (
    .wr_clk (clk),
    .wr_en  (wr_en),
    .wr_addr(wr_bin[cdc_stream_pkg::addr_width-1:0]),
    .wr_data(wr_data),
    .rd_clk (rd_clk),
    .rd_en  (rd_en),
    .rd_addr(rd_bin[cdc_stream_pkg::addr_width-1:0]),
    .rd_data(rd_data)
  );

  gray_counter #(
    .width(cdc_stream_pkg::ptr_width)
  ) wr_ptr (
    .clk  (clk),
    .reset(reset),
    .en   (wr_en),
    .bin  (wr_bin),
    .gray (wr_gray)
  );

  gray_counter #(
    .width(cdc_stream_pkg::ptr_width)
  ) rd_ptr (
    .clk  (rd_clk),
    .reset(rd_reset),
    .en   (rd_en),
    .bin  (rd_bin),
    .gray (rd_gray)
  );

  // read gray into clk domain
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_gray_sync1 <= '0;
      rd_gray_sync2 <= '0;
    end else begin
      rd_gray_sync1 <= rd_gray;
      rd_gray_sync2 <= rd_gray_sync1;
    end
  end

  // write gray into rd_clk domain
  always_ff @(posedge rd_clk) begin
    if (rd_reset) begin
      wr_gray_sync1 <= '0;
      wr_gray_sync2 <= '0;
    end else begin
      wr_gray_sync1 <= wr_gray;
      wr_gray_sync2 <= wr_gray_sync1;
    end
  end

  // stale read pointer only overstates the fill level, so full is safe
  assign rd_bin_wr  = cdc_stream_pkg::gray_to_bin(rd_gray_sync2);
  assign fill_level = wr_bin - rd_bin_wr;
  assign full       = fill_level == cdc_stream_pkg::ptr_width'(cdc_stream_pkg::fifo_depth);

  // likewise a stale write pointer can only make empty linger
  assign empty = wr_gray_sync2 == rd_gray;

endmodule

`default_nettype wire

// ==== async_fifo/dual_port_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

// separate write and read clocks, registered read
module dual_port_ram #(
  parameter type payload_t = logic [cdc_stream_pkg::data_width-1:0]
) (
  input  logic                                wr_clk,
  input  logic                                wr_en,
  input  logic [cdc_stream_pkg::addr_width-1:0] wr_addr,
  input  payload_t                            wr_data,
  input  logic                                rd_clk,
  input  logic                                rd_en,
  input  logic [cdc_stream_pkg::addr_width-1:0] rd_addr,
  output payload_t                            rd_data
);

  payload_t mem [cdc_stream_pkg::fifo_depth];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge rd_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== common/cdc_stream_pkg.sv ====
package cdc_stream_pkg;

  // stream widths
  localparam int data_width = 16;
  localparam int seq_width  = 8;

  // fifo geometry
  localparam int fifo_depth = 16;
  localparam int addr_width = 4;
  // one extra bit tells a full FIFO apart from an empty one
  localparam int ptr_width  = addr_width + 1;

  localparam int drop_width = 16;

  // fifo payload, also what the receiver presents
  typedef struct packed {
    logic [seq_width-1:0]  seq;
    logic [data_width-1:0] data;
  } sample_t;

  function automatic logic [ptr_width-1:0] bin_to_gray(
    input logic [ptr_width-1:0] bin
  );
    return bin ^ (bin >> 1);
  endfunction

  function automatic logic [ptr_width-1:0] gray_to_bin(
    input logic [ptr_width-1:0] gray
  );
    logic [ptr_width-1:0] bin;
    bin[ptr_width-1] = gray[ptr_width-1];
    // each binary bit folds in all gray bits above it
    for (int i = ptr_width - 1; i > 0; i--) begin
      bin[i-1] = bin[i] ^ gray[i-1];
    end
    return bin;
  endfunction

endpackage

// ==== hw/cdc_stream_top.sv ====
`timescale 1ns/1ns
`default_nettype none

// framer -> async fifo -> receiver
module cdc_stream_top (
  input  logic                                  clk,
  input  logic                                  rd_clk,
  input  logic                                  reset,
  input  logic                                  in_valid,
  input  logic [cdc_stream_pkg::data_width-1:0] in_data,
  output logic                                  out_valid,
  output cdc_stream_pkg::sample_t               out_sample,
  output logic                                  out_gap,
  output logic [cdc_stream_pkg::drop_width-1:0] drop_count
);

  // write domain
  logic                    wr_en;
  cdc_stream_pkg::sample_t wr_data;
  logic                    full;

  // read domain
  logic                    rd_en;
  cdc_stream_pkg::sample_t rd_data;
  logic                    empty;
  logic                    rd_reset;

  sample_framer framer (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .full      (full),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .drop_count(drop_count)
  );

  async_fifo #(
    .payload_t(cdc_stream_pkg::sample_t)
  ) fifo (
    .clk     (clk),
    .reset   (reset),
    .wr_en   (wr_en),
    .wr_data (wr_data),
    .full    (full),
    .rd_clk  (rd_clk),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .empty   (empty),
    .rd_reset(rd_reset)
  );

  sample_receiver receiver (
    .rd_clk    (rd_clk),
    .rd_reset  (rd_reset),
    .empty     (empty),
    .rd_data   (rd_data),
    .rd_en     (rd_en),
    .out_valid (out_valid),
    .out_sample(out_sample),
    .out_gap   (out_gap)
  );

endmodule

`default_nettype wire

// ==== hw/gray_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

// fifo pointer with binary and gray views
module gray_counter #(
  parameter int width = cdc_stream_pkg::ptr_width
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             en,
  output logic [width-1:0] bin,
  output logic [width-1:0] gray
);

  logic [width-1:0] bin_next;

  assign bin_next = bin + 1'b1;

  // gray is registered from the next value so it stays in step with bin
  // and only one bit flips per increment
  always_ff @(posedge clk) begin
    if (reset) begin
      bin  <= '0;
      gray <= '0;
    end else if (en) begin
      bin  <= bin_next;
      gray <= cdc_stream_pkg::bin_to_gray(bin_next);
    end
  end

endmodule

`default_nettype wire

// ==== hw/sample_framer.sv ====
`timescale 1ns/1ns
`default_nettype none

// write side producer: tags samples, drops them when the fifo is full
module sample_framer (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   in_valid,
  input  logic [cdc_stream_pkg::data_width-1:0]  in_data,
  input  logic                                   full,
  output logic                                   wr_en,
  output cdc_stream_pkg::sample_t                wr_data,
  output logic [cdc_stream_pkg::drop_width-1:0]  drop_count
);

  logic [cdc_stream_pkg::seq_width-1:0] seq_count;
  // a tagged sample sits in wr_data this cycle
  logic                                 offer;
  logic                                 drop;

  // sequence advances for every input, kept or not
  always_ff @(posedge clk) begin
    if (reset) begin
      seq_count <= '0;
      offer     <= 1'b0;
    end else begin
      offer <= in_valid;
      if (in_valid) begin
        seq_count <= seq_count + 1'b1;
      end
    end
  end

  // payload register
  always_ff @(posedge clk) begin
    if (in_valid) begin
      wr_data.seq  <= seq_count;
      wr_data.data <= in_data;
    end
  end

  // full is decided in the same cycle as the offer
  assign wr_en = offer && !full;
  assign drop  = offer && full;

  // saturating drop counter
  always_ff @(posedge clk) begin
    if (reset) begin
      drop_count <= '0;
    end else if (drop && (drop_count != '1)) begin
      drop_count <= drop_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/sample_receiver.sv ====
`timescale 1ns/1ns
`default_nettype none

// read side consumer, pops on not-empty and flags sequence gaps
module sample_receiver (
  input  logic                    rd_clk,
  input  logic                    rd_reset,
  input  logic                    empty,
  input  cdc_stream_pkg::sample_t rd_data,
  output logic                    rd_en,
  output logic                    out_valid,
  output cdc_stream_pkg::sample_t out_sample,
  output logic                    out_gap
);

  logic [cdc_stream_pkg::seq_width-1:0] last_seq;
  logic [cdc_stream_pkg::seq_width-1:0] expected_seq;
  // no previous output yet, so no gap can be judged
  logic                                 have_last;

  // no back-pressure here, drain whenever there is data
  assign rd_en = !empty;

  // ram read data lands one cycle after rd_en
  always_ff @(posedge rd_clk) begin
    if (rd_reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= rd_en;
    end
  end

  assign out_sample = rd_data;

  // remember the seq of each presented sample
  always_ff @(posedge rd_clk) begin
    if (rd_reset) begin
      have_last <= 1'b0;
    end else if (out_valid) begin
      have_last <= 1'b1;
    end
  end

  always_ff @(posedge rd_clk) begin
    if (out_valid) begin
      last_seq <= rd_data.seq;
    end
  end

  // wraps at 256
  assign expected_seq = last_seq + 1'b1;

  assign out_gap = out_valid && have_last && (rd_data.seq != expected_seq);

endmodule

`default_nettype wire

// ==== sim.f ====
common/cdc_stream_pkg.sv
hw/gray_counter.sv
async_fifo/dual_port_ram.sv
async_fifo/async_fifo.sv
hw/sample_framer.sv
hw/sample_receiver.sv
hw/cdc_stream_top.sv
test/cdc_stream_props.sv
test/cdc_stream_tb.sv

// ==== test/cdc_stream_props.sv ====
`timescale 1ns/1ns

// fifo handshake and flag properties
module cdc_stream_props (
  input logic                                        clk,
  input logic                                        reset,
  input logic                                        wr_en,
  input logic                                        full,
  input logic                                        rd_clk,
  input logic                                        rd_reset,
  input logic                                        rd_en,
  input logic                                        empty,
  input logic [$bits(cdc_stream_pkg::sample_t)-1:0] rd_data
);

  // failed assertions so far
  int error_count = 0;

  assert property (@(posedge clk) disable iff (reset) !(wr_en && full))
    else begin
      $error("write while full");
      error_count++;
    end

  // read side is undefined until its reset has crossed over
  assert property (@(posedge rd_clk) disable iff (rd_reset !== 1'b0) !(rd_en && empty))
    else begin
      $error("read while empty");
      error_count++;
    end

  // registered ram output lands one cycle after rd_en
  assert property (@(posedge rd_clk) disable iff (rd_reset !== 1'b0)
    rd_en |=> !$isunknown(rd_data))
    else begin
      $error("read data unknown one cycle after rd_en");
      error_count++;
    end

  // stale pointers may overlap the flags only briefly
  assert property (@(posedge clk) disable iff (reset)
    (full && empty) |-> ##[1:3] !(full && empty))
    else begin
      $error("full and empty high together past the sync window");
      error_count++;
    end

endmodule

bind async_fifo cdc_stream_props props (
  .clk     (clk),
  .reset   (reset),
  .wr_en   (wr_en),
  .full    (full),
  .rd_clk  (rd_clk),
  .rd_reset(rd_reset),
  .rd_en   (rd_en),
  .empty   (empty),
  .rd_data (rd_data)
);

// ==== test/cdc_stream_tb.sv ====
`timescale 1ns/1ns

module cdc_stream_tb;

  localparam int clk_period = 8;
  // clk cycles allowed for any single wait
  localparam int wait_limit = 4000;

  logic                                  clk;
  logic                                  rd_clk;
  logic                                  reset;
  logic                                  in_valid;
  logic [cdc_stream_pkg::data_width-1:0] in_data;
  logic                                  out_valid;
  cdc_stream_pkg::sample_t               out_sample;
  logic                                  out_gap;
  logic [cdc_stream_pkg::drop_width-1:0] drop_count;

  int     rd_period = 8;
  integer seed = 2;

  // sent data, indexed by the seq the framer will give it
  logic [cdc_stream_pkg::data_width-1:0] sent_data [256];
  logic [cdc_stream_pkg::seq_width-1:0]  next_seq = '0;
  int                                    sent_count = 0;

  // writes the fifo accepted
  int                                   wr_count = 0;
  logic [cdc_stream_pkg::seq_width-1:0] last_wr_seq = '0;

  int                                   out_count = 0;
  logic                                 have_prev = 1'b0;
  logic [cdc_stream_pkg::seq_width-1:0] prev_seq = '0;
  // seq must arrive strictly in order
  logic                                 lossless = 1'b1;

  cdc_stream_top uut (
    .clk       (clk),
    .rd_clk    (rd_clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_sample(out_sample),
    .out_gap   (out_gap),
    .drop_count(drop_count)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // period may change between phases
  initial begin
    rd_clk = 1'b0;
    forever begin
      #(rd_period / 2) rd_clk = 1'b1;
      #(rd_period - rd_period / 2) rd_clk = 1'b0;
    end
  end

  function automatic cdc_stream_pkg::sample_t expected_sample(
    input logic [cdc_stream_pkg::seq_width-1:0] seq
  );
    cdc_stream_pkg::sample_t s;
    s.seq  = seq;
    s.data = sent_data[seq];
    return s;
  endfunction

  task automatic abort_run(input string reason);
    $display("Result: FAILED");
    $fatal(1, "%s", reason);
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      abort_run("value mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout after %0d clk cycles: %s", wait_limit, what);
    abort_run("wait timed out");
  endtask

  task automatic send_samples(input int count, input int spacing);
    for (int i = 0; i < count; i++) begin
      in_valid = 1'b1;
      in_data  = cdc_stream_pkg::data_width'($random(seed));
      sent_data[next_seq] = in_data;
      next_seq++;
      sent_count++;
      @(posedge clk);
      #1;
      if (spacing > 1) begin
        in_valid = 1'b0;
        repeat (spacing - 1) begin
          @(posedge clk);
          #1;
        end
      end
    end
    in_valid = 1'b0;
  endtask

  task automatic wait_rd_reset();
    int cycles;
    cycles = 0;
    while (uut.rd_reset !== 1'b0) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > wait_limit) begin
        report_timeout("read domain reset never released");
      end
    end
  endtask

  // nothing may come out before the first input
  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #1;
      check("out_valid", out_valid, 0);
      check("out_gap", out_gap, 0);
      check("drop_count", drop_count, 0);
    end
  endtask

  task automatic wait_drain();
    int cycles;
    int settled_count;
    cycles = 0;
    while (out_count + int'(drop_count) != sent_count) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > wait_limit) begin
        report_timeout("outputs and drops did not account for every input");
      end
    end
    settled_count = out_count;
    repeat (40) begin
      @(posedge clk);
    end
    #1;
    check("out_count after drain", out_count, settled_count);
    check("out_count", out_count, wr_count);
    check("out_sample.seq of last output", prev_seq, last_wr_seq);
  endtask

  // accepted writes, seen mid-cycle
  always @(negedge clk) begin
    if (uut.wr_en === 1'b1) begin
      wr_count++;
      last_wr_seq = uut.wr_data.seq;
    end
  end

  // a failed assertion in the bound checker ends the run
  always @(uut.fifo.props.error_count) begin
    if (uut.fifo.props.error_count != 0) begin
      abort_run("an assertion on the FIFO failed");
    end
  end

  always @(negedge rd_clk) begin : compare_outputs
    logic [cdc_stream_pkg::seq_width-1:0] seq_after_prev;
    logic                                 gap_expected;
    if (out_valid === 1'b1) begin
      seq_after_prev = prev_seq + 1'b1;
      gap_expected   = have_prev && (out_sample.seq != seq_after_prev);
      check("out_sample", out_sample, expected_sample(out_sample.seq));
      check("out_gap", out_gap, gap_expected);
      if (lossless && have_prev) begin
        check("out_sample.seq", out_sample.seq, seq_after_prev);
      end
      prev_seq  = out_sample.seq;
      have_prev = 1'b1;
      out_count++;
    end
  end

  initial begin
    reset    = 1'b1;
    in_valid = 1'b0;
    in_data  = '0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    wait_rd_reset();
    check_idle(20);

    // lossless, equal clocks
    rd_period = 8;
    send_samples(40, 4);
    wait_drain();
    check("drop_count", drop_count, 0);

    // lossless, fast reader
    rd_period = 5;
    send_samples(40, 4);
    wait_drain();
    check("drop_count", drop_count, 0);

    // slow reader forces overflow
    lossless  = 1'b0;
    rd_period = 21;
    send_samples(100, 1);
    wait_drain();
    check("drop_count nonzero", drop_count != 0, 1);

    if (uut.fifo.props.error_count == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      abort_run("an assertion on the FIFO failed");
    end
  end

endmodule
